//--- bench/fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_tb;

  localparam int             CLK_PERIOD     = 4;
  localparam int             NUM_CYCLES     = 3000;
  localparam int             BTB_INDEX_BITS = 4;
  localparam int             BTB_ENTRIES    = 1 << BTB_INDEX_BITS;
  localparam fetch_pkg::pc_t RESET_PC       = 32'h0000_0040;
  // Redirects and BTB entries stay in a small window so lookups hit often
  localparam fetch_pkg::pc_t WINDOW_BASE    = 32'h0000_0040;
  localparam int             WINDOW_WORDS   = 64;

  logic                clk = 1'b0;
  logic                rst_n;
  logic                stall;
  logic                redirect;
  fetch_pkg::pc_t      redirect_pc;
  fetch_pkg::btb_upd_t btb_upd;
  logic                imem_ren;
  fetch_pkg::pc_t      imem_raddr;
  fetch_pkg::instr_t   imem_rdata = '0;
  logic                m_valid;
  fetch_pkg::if_id_t   if_id;

  // Reference model state
  logic                ref_started;
  logic                ref_pc_valid;
  fetch_pkg::pc_t      ref_pc;
  logic                ref_valid;
  fetch_pkg::if_id_t   ref_pkt;
  logic                mir_valid [BTB_ENTRIES];
  fetch_pkg::pc_t      mir_tag   [BTB_ENTRIES];
  fetch_pkg::pc_t      mir_tgt   [BTB_ENTRIES];
  logic                mir_taken [BTB_ENTRIES];

  // Values remembered for the explicit hold and redirect checks
  logic                hold_next;
  logic                after_redirect;
  logic                held_valid;
  fetch_pkg::if_id_t   held_pkt;

  int                  errors   = 0;
  int                  accepted = 0;
  int                  taken_seen = 0;
  int unsigned         seed_val;

  fetch_unit #(
    .RESET_PC       (RESET_PC),
    .BTB_INDEX_BITS (BTB_INDEX_BITS)
  ) i_dut (
    .clk           (clk),
    .rst_n_i       (rst_n),
    .stall_i       (stall),
    .redirect_i    (redirect),
    .redirect_pc_i (redirect_pc),
    .btb_upd_i     (btb_upd),
    .imem_ren_o    (imem_ren),
    .imem_raddr_o  (imem_raddr),
    .imem_rdata_i  (imem_rdata),
    .m_valid_o     (m_valid),
    .if_id_o       (if_id)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Memory content is a fixed mix of every address bit
  function automatic fetch_pkg::instr_t scramble_word(fetch_pkg::pc_t addr);
    return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]} ^ 32'h5a5a_c3c3;
  endfunction

  // Block RAM with one cycle of read latency
  always @(posedge clk) begin
    if (imem_ren) begin
      imem_rdata <= scramble_word(imem_raddr);
    end
  end

  function automatic fetch_pkg::pc_t window_addr();
    return WINDOW_BASE + fetch_pkg::pc_t'(($urandom % WINDOW_WORDS) * 4);
  endfunction

  function automatic fetch_pkg::bpred_t mirror_lookup(fetch_pkg::pc_t pc);
    fetch_pkg::bpred_t p;
    int                idx;
    p   = '0;
    idx = int'((pc >> 2) % BTB_ENTRIES);
    if (mir_valid[idx] && mir_tag[idx] == (pc >> (BTB_INDEX_BITS + 2))) begin
      p.hit   = 1'b1;
      p.taken = mir_taken[idx];
      p.tgt   = mir_tgt[idx];
    end
    return p;
  endfunction

  task automatic report_failure();
    $display("TB FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_packet(string name, fetch_pkg::if_id_t got, fetch_pkg::if_id_t exp);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0d ns: %s is %h, expected %h", $time, name, got, exp);
      report_failure();
    end
  endtask

  task automatic check_pc(string name, fetch_pkg::pc_t got, fetch_pkg::pc_t exp);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0d ns: %s is %h, expected %h", $time, name, got, exp);
      report_failure();
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0d ns: %s is %b, expected %b", $time, name, got, exp);
      report_failure();
    end
  endtask

  // Runs between edges, compares the DUT with the model and steps the model
  task automatic compare_and_step();
    fetch_pkg::bpred_t pred;
    fetch_pkg::pc_t    next_pc;
    logic              load;
    int                idx;
    if (!rst_n) begin
      check_flag("m_valid_o", m_valid, 1'b0);
      check_flag("imem_ren_o", imem_ren, 1'b0);
      ref_started    = 1'b0;
      ref_pc_valid   = 1'b0;
      ref_pc         = RESET_PC;
      ref_valid      = 1'b0;
      hold_next      = 1'b0;
      after_redirect = 1'b0;
      for (int i = 0; i < BTB_ENTRIES; i++) begin
        mir_valid[i] = 1'b0;
      end
      return;
    end
    if (after_redirect) begin
      check_flag("m_valid_o", m_valid, 1'b0);
    end
    if (hold_next) begin
      check_flag("m_valid_o", m_valid, held_valid);
      if (held_valid) begin
        check_packet("if_id_o", if_id, held_pkt);
      end
    end
    check_flag("m_valid_o", m_valid, ref_valid);
    if (ref_valid) begin
      check_packet("if_id_o", if_id, ref_pkt);
      if (!stall) begin
        accepted++;
        if (ref_pkt.bpred.hit && ref_pkt.bpred.taken) begin
          taken_seen++;
        end
      end
    end
    // Next-PC rule
    pred = mirror_lookup(ref_pc);
    load = ref_started && (redirect || !stall);
    if (redirect) begin
      next_pc = redirect_pc;
    end else if (!ref_pc_valid) begin
      next_pc = RESET_PC;
    end else if (pred.hit && pred.taken) begin
      next_pc = pred.tgt;
    end else begin
      next_pc = ref_pc + 32'd4;
    end
    check_flag("imem_ren_o", imem_ren, load);
    if (load) begin
      check_pc("imem_raddr_o", imem_raddr, next_pc);
    end
    hold_next      = stall && !redirect;
    after_redirect = redirect;
    held_valid     = ref_valid;
    held_pkt       = ref_pkt;
    // IF/ID register, flush wins over stall
    if (redirect) begin
      ref_valid = 1'b0;
    end else if (!stall) begin
      ref_valid            = ref_pc_valid;
      ref_pkt.instr        = scramble_word(ref_pc);
      ref_pkt.pc           = ref_pc;
      ref_pkt.pc_plus4     = ref_pc + 32'd4;
      ref_pkt.bpred        = pred;
    end
    if (load) begin
      ref_pc       = next_pc;
      ref_pc_valid = 1'b1;
    end
    ref_started = 1'b1;
    if (btb_upd.valid) begin
      idx            = int'((btb_upd.pc >> 2) % BTB_ENTRIES);
      mir_valid[idx] = 1'b1;
      mir_tag[idx]   = btb_upd.pc >> (BTB_INDEX_BITS + 2);
      mir_tgt[idx]   = btb_upd.tgt;
      mir_taken[idx] = btb_upd.taken;
    end
  endtask

  always @(negedge clk) begin
    compare_and_step();
  end

  task automatic drive_random();
    fetch_pkg::btb_upd_t upd;
    logic                do_stall;
    logic                do_redirect;
    do_stall    = ($urandom % 100) < 25;
    do_redirect = ($urandom % 100) < 5;
    upd         = '0;
    // Execute writes the BTB only while decode is stalled
    if (do_stall && ($urandom % 2) == 0) begin
      upd.valid = 1'b1;
      upd.pc    = window_addr();
      upd.tgt   = window_addr();
      upd.taken = ($urandom % 2) == 1;
    end
    stall       <= do_stall;
    redirect    <= do_redirect;
    redirect_pc <= window_addr();
    btb_upd     <= upd;
  endtask

  initial begin
    seed_val    = $urandom(32'h7ae2);
    rst_n       = 1'b0;
    stall       = 1'b0;
    redirect    = 1'b0;
    redirect_pc = '0;
    btb_upd     = '0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    repeat (NUM_CYCLES) begin
      @(posedge clk);
      drive_random();
    end
    @(posedge clk);
    stall    <= 1'b0;
    redirect <= 1'b0;
    btb_upd  <= '0;
    @(negedge clk);
    if (accepted == 0) begin
      errors++;
      $display("No instruction packet reached decode during the run");
    end
    if (taken_seen == 0) begin
      errors++;
      $display("No packet carried a predicted-taken branch during the run");
    end
    if (errors == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      report_failure();
    end
  end

  // Watchdog
  initial begin
    #((NUM_CYCLES + 100) * CLK_PERIOD);
    $display("Timeout: the run did not finish in the expected time");
    report_failure();
  end

endmodule

`default_nettype wire

//--- common/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  // Address and data width of the core
  parameter int XLEN = 32;

  typedef logic [XLEN-1:0] pc_t;

  // Base ISA only, every instruction is one full word
  typedef logic [31:0] instr_t;

  // Prediction made for one fetch PC
  typedef struct packed {
    logic hit;
    logic taken;
    pc_t  tgt;
  } bpred_t;

  // One BTB write from execute
  typedef struct packed {
    logic valid;
    pc_t  pc;
    pc_t  tgt;
    logic taken;
  } btb_upd_t;

  // One fetched instruction handed to decode
  typedef struct packed {
    instr_t instr;
    pc_t    pc;
    pc_t    pc_plus4;
    bpred_t bpred;
  } if_id_t;

endpackage

`default_nettype wire

//--- fetch_stage/bpred_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module bpred_buffer (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              advance_i,
  input  logic              flush_i,
  input  fetch_pkg::bpred_t bpred_i,
  output fetch_pkg::bpred_t bpred_o
);

  fetch_pkg::bpred_t bpred_q;

  // Bubbles must not carry a stale prediction into decode
  // Target is only meaningful with hit set, so it keeps its old value
  always_ff @(posedge clk) begin
    if (!rst_n_i || flush_i) begin
      bpred_q.hit   <= 1'b0;
      bpred_q.taken <= 1'b0;
    end else if (advance_i) begin
      bpred_q <= bpred_i;
    end
  end

  assign bpred_o = bpred_q;

endmodule

`default_nettype wire

//--- fetch_stage/fetch_bram_path.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_bram_path (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              advance_i,
  input  logic              flush_i,
  input  fetch_pkg::pc_t    pc_i,
  input  logic              pc_valid_i,
  input  fetch_pkg::instr_t imem_rdata_i,
  output logic              valid_o,
  output fetch_pkg::instr_t instr_o,
  output fetch_pkg::pc_t    pc_o,
  output fetch_pkg::pc_t    pc_plus4_o
);

  logic              valid_q;
  fetch_pkg::instr_t instr_q;
  fetch_pkg::pc_t    pc_q;
  fetch_pkg::pc_t    pc_plus4_q;
  fetch_pkg::pc_t    pc_plus4;

  // Sequential successor, handed on for link registers and mispredict recovery
  assign pc_plus4 = pc_i + fetch_pkg::pc_t'(4);

  // Flush wins over stall so a redirect never leaves a wrong-path slot behind
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (advance_i) begin
      valid_q <= pc_valid_i;
    end
  end

  // Block RAM data lines up with the PC register, so both are captured
  // on the same edge
  always_ff @(posedge clk) begin
    if (advance_i) begin
      instr_q    <= imem_rdata_i;
      pc_q       <= pc_i;
      pc_plus4_q <= pc_plus4;
    end
  end

  assign valid_o    = valid_q;
  assign instr_o    = instr_q;
  assign pc_o       = pc_q;
  assign pc_plus4_o = pc_plus4_q;

endmodule

`default_nettype wire

//--- fetch_stage/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              stall_i,
  input  logic              redirect_i,
  input  fetch_pkg::pc_t    pc_i,
  input  logic              pc_valid_i,
  input  fetch_pkg::instr_t imem_rdata_i,
  input  fetch_pkg::bpred_t bpred_i,
  output logic              m_valid_o,
  output fetch_pkg::if_id_t if_id_o
);

  logic              advance;
  logic              flush;

  fetch_pkg::instr_t instr_id;
  fetch_pkg::pc_t    pc_id;
  fetch_pkg::pc_t    pc_plus4_id;
  fetch_pkg::bpred_t bpred_id;

  // Decode back-pressure freezes both halves of IF/ID together
  assign advance = !stall_i;
  // A redirect from execute kills whatever sits in IF/ID
  assign flush   = redirect_i;

  fetch_bram_path i_bram_path (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .advance_i    (advance),
    .flush_i      (flush),
    .pc_i         (pc_i),
    .pc_valid_i   (pc_valid_i),
    .imem_rdata_i (imem_rdata_i),
    .valid_o      (m_valid_o),
    .instr_o      (instr_id),
    .pc_o         (pc_id),
    .pc_plus4_o   (pc_plus4_id)
  );

  bpred_buffer i_bpred_buffer (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .advance_i (advance),
    .flush_i   (flush),
    .bpred_i   (bpred_i),
    .bpred_o   (bpred_id)
  );

  always_comb begin
    if_id_o.instr    = instr_id;
    if_id_o.pc       = pc_id;
    if_id_o.pc_plus4 = pc_plus4_id;
    if_id_o.bpred    = bpred_id;
  end

  a_hold_on_stall: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    stall_i && m_valid_o && !redirect_i |=> m_valid_o && $stable(if_id_o)
  );

endmodule

`default_nettype wire

//--- logic/branch_target_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module branch_target_buffer #(
  parameter int BTB_INDEX_BITS = 4
) (
  input  logic                clk,
  input  logic                rst_n_i,
  input  fetch_pkg::pc_t      lookup_pc_i,
  output fetch_pkg::bpred_t   bpred_o,
  input  fetch_pkg::btb_upd_t upd_i
);

  localparam int ENTRIES = 1 << BTB_INDEX_BITS;

  // Tag covers everything above the index and the word offset
  localparam int TAG_W = fetch_pkg::XLEN - BTB_INDEX_BITS - 2;

  typedef struct packed {
    logic [TAG_W-1:0] tag;
    fetch_pkg::pc_t   tgt;
    logic             taken;
  } btb_entry_t;

  logic [ENTRIES-1:0]        valid_q;
  btb_entry_t                entry_q [ENTRIES];

  logic [BTB_INDEX_BITS-1:0] rd_idx;
  logic [TAG_W-1:0]          rd_tag;
  btb_entry_t                rd_entry;
  logic                      rd_hit;

  logic [BTB_INDEX_BITS-1:0] wr_idx;
  logic [TAG_W-1:0]          wr_tag;

  // Lookup side
  assign rd_idx   = lookup_pc_i[BTB_INDEX_BITS+1:2];
  assign rd_tag   = lookup_pc_i[fetch_pkg::XLEN-1:BTB_INDEX_BITS+2];
  assign rd_entry = entry_q[rd_idx];
  assign rd_hit   = valid_q[rd_idx] && (rd_entry.tag == rd_tag);

  always_comb begin
    bpred_o.hit   = rd_hit;
    bpred_o.taken = rd_hit && rd_entry.taken;
    // Target reads as zero on a miss
    bpred_o.tgt   = rd_hit ? rd_entry.tgt : '0;
  end

  // Update side
  assign wr_idx = upd_i.pc[BTB_INDEX_BITS+1:2];
  assign wr_tag = upd_i.pc[fetch_pkg::XLEN-1:BTB_INDEX_BITS+2];

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      valid_q <= '0;
    end else if (upd_i.valid) begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  // A write replaces the whole entry
  always_ff @(posedge clk) begin
    if (upd_i.valid) begin
      entry_q[wr_idx].tag   <= wr_tag;
      entry_q[wr_idx].tgt   <= upd_i.tgt;
      entry_q[wr_idx].taken <= upd_i.taken;
    end
  end

  // A lookup of the written PC sees the new entry from the next cycle
  a_update_visible: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    upd_i.valid |=> lookup_pc_i != $past(upd_i.pc) ||
      (bpred_o.hit && bpred_o.taken == $past(upd_i.taken) &&
       bpred_o.tgt == $past(upd_i.tgt))
  );

endmodule

`default_nettype wire

//--- logic/fetch_pc.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_pc #(
  parameter fetch_pkg::pc_t RESET_PC = '0
) (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              stall_i,
  input  logic              redirect_i,
  input  fetch_pkg::pc_t    redirect_pc_i,
  input  fetch_pkg::bpred_t bpred_i,
  output fetch_pkg::pc_t    pc_o,
  output logic              pc_valid_o,
  output logic              imem_ren_o,
  output fetch_pkg::pc_t    imem_raddr_o
);

  fetch_pkg::pc_t pc_q;
  fetch_pkg::pc_t pc_next;
  logic           pc_valid_q;
  logic           started_q;
  logic           load;

  // First request goes out one cycle after reset is released
  // Redirect overrides back-pressure from decode
  assign load = started_q && (redirect_i || !stall_i);

  always_comb begin
    if (redirect_i) begin
      pc_next = redirect_pc_i;
    end else if (!pc_valid_q) begin
      pc_next = RESET_PC;
    end else if (bpred_i.hit && bpred_i.taken) begin
      // Follow a predicted-taken branch straight to its target
      pc_next = bpred_i.tgt;
    end else begin
      pc_next = pc_q + fetch_pkg::pc_t'(4);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      started_q  <= 1'b0;
      pc_valid_q <= 1'b0;
      pc_q       <= RESET_PC;
    end else begin
      started_q <= 1'b1;
      if (load) begin
        pc_q       <= pc_next;
        pc_valid_q <= 1'b1;
      end
    end
  end

  // The memory reads the same address the PC register loads
  assign imem_ren_o   = load;
  assign imem_raddr_o = pc_next;

  assign pc_o       = pc_q;
  assign pc_valid_o = pc_valid_q;

  // Every read leaves the PC register holding the address that was read
  a_read_loads_pc: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    imem_ren_o |=> pc_valid_o && pc_o == $past(imem_raddr_o)
  );

endmodule

`default_nettype wire

//--- logic/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
  parameter fetch_pkg::pc_t RESET_PC       = '0,
  parameter int             BTB_INDEX_BITS = 4
) (
  input  logic                clk,
  input  logic                rst_n_i,
  input  logic                stall_i,
  input  logic                redirect_i,
  input  fetch_pkg::pc_t      redirect_pc_i,
  input  fetch_pkg::btb_upd_t btb_upd_i,
  output logic                imem_ren_o,
  output fetch_pkg::pc_t      imem_raddr_o,
  input  fetch_pkg::instr_t   imem_rdata_i,
  output logic                m_valid_o,
  output fetch_pkg::if_id_t   if_id_o
);

  fetch_pkg::pc_t    pc;
  logic              pc_valid;
  fetch_pkg::bpred_t bpred;

  fetch_pc #(
    .RESET_PC (RESET_PC)
  ) i_fetch_pc (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .stall_i       (stall_i),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .bpred_i       (bpred),
    .pc_o          (pc),
    .pc_valid_o    (pc_valid),
    .imem_ren_o    (imem_ren_o),
    .imem_raddr_o  (imem_raddr_o)
  );

  // Lookup runs on the PC register, in step with the memory data
  branch_target_buffer #(
    .BTB_INDEX_BITS (BTB_INDEX_BITS)
  ) i_btb (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .lookup_pc_i (pc),
    .bpred_o     (bpred),
    .upd_i       (btb_upd_i)
  );

  fetch_stage i_fetch_stage (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .stall_i      (stall_i),
    .redirect_i   (redirect_i),
    .pc_i         (pc),
    .pc_valid_i   (pc_valid),
    .imem_rdata_i (imem_rdata_i),
    .bpred_i      (bpred),
    .m_valid_o    (m_valid_o),
    .if_id_o      (if_id_o)
  );

endmodule

`default_nettype wire

//--- project.f
common/fetch_pkg.sv
logic/fetch_pc.sv
logic/branch_target_buffer.sv
fetch_stage/fetch_bram_path.sv
fetch_stage/bpred_buffer.sv
fetch_stage/fetch_stage.sv
logic/fetch_unit.sv
bench/fetch_tb.sv
